// File: src/alu_pkg.sv
package alu_pkg;

  localparam int data_width = 16;
  localparam int shamt_width = $clog2(data_width);  // rotate amount bits

  typedef logic [data_width-1:0] data_t;

  // encodings follow the legacy ALU opcode map
  typedef enum logic [5:0] {
    op_add = 6'b001101,
    op_sub = 6'b001110,
    op_shr = 6'b001111,
    op_shl = 6'b010000,
    op_mul = 6'b010001,
    op_inc = 6'b010101,
    op_dec = 6'b010110,
    op_and = 6'b010111,
    op_or  = 6'b011000,
    op_xor = 6'b011001,
    op_not = 6'b011010,
    op_ror = 6'b011011,
    op_rol = 6'b011100
  } alu_op_e;

  localparam int flag_ovf   = 0;
  localparam int flag_carry = 1;  // borrow for sub/dec
  localparam int flag_neg   = 2;
  localparam int flag_zero  = 3;

  typedef logic [3:0] flags_t;

  function automatic logic is_arith(input alu_op_e op);
    return op inside {op_add, op_sub, op_mul, op_inc, op_dec};
  endfunction

  function automatic logic is_logic(input alu_op_e op);
    return op inside {op_and, op_or, op_xor, op_not, op_shr, op_shl, op_ror, op_rol};
  endfunction

  function automatic logic is_known(input alu_op_e op);
    return is_arith(op) || is_logic(op);
  endfunction

endpackage

// File: src/operand_if.sv
interface operand_if
  import alu_pkg::*;
();

  logic    valid;  // one cycle per issued op
  alu_op_e op;
  data_t   a;
  data_t   b;
  data_t   ref_val;  // value the carry/ovf rules compare against

  modport producer (
    output valid,
    output op,
    output a,
    output b,
    output ref_val
  );

  modport consumer (
    input valid,
    input op,
    input a,
    input b,
    input ref_val
  );

endinterface

// File: src/operand_select.sv
module operand_select
  import alu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    en,
  input  alu_op_e opcode,
  input  data_t   acc,
  input  data_t   x,
  input  data_t   y,
  input  data_t   immediate,
  input  logic    ra,
  operand_if.producer issue
);

  data_t reg_val;
  data_t a_next;
  data_t b_next;
  data_t ref_next;
  logic  imm_zero;
  logic  accept;

  assign accept = en && is_known(opcode);

  always_comb begin
    reg_val  = ra ? y : x;
    imm_zero = (immediate == '0);
    a_next   = reg_val;  // reg op imm by default
    b_next   = immediate;
    ref_next = immediate;
    case (opcode)
      op_inc, op_dec: begin
        b_next   = data_t'(1);
        ref_next = data_t'(1);
      end
      op_not: ;  // only a matters
      op_add, op_mul: begin
        a_next   = imm_zero ? acc : immediate;
        b_next   = reg_val;
        ref_next = imm_zero ? acc : immediate;
      end
      default: begin
        if (imm_zero) begin  // accumulator path
          a_next   = acc;
          b_next   = reg_val;
          ref_next = acc;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= accept;  // unknown opcodes dropped here
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue.op      <= opcode;
      issue.a       <= a_next;
      issue.b       <= b_next;
      issue.ref_val <= ref_next;
    end
  end

endmodule

// File: src/arith_unit.sv
module arith_unit
  import alu_pkg::*;
(
  operand_if.consumer issue,
  output data_t       result,
  output logic        ovf,
  output logic        carry
);

  logic is_sub;
  logic same_sign;
  logic sign_flip;

  always_comb begin
    is_sub = 1'b0;
    case (issue.op)
      op_add, op_inc: begin
        result = issue.a + issue.b;
      end
      op_mul: begin
        result = issue.a * issue.b;  // low half only
      end
      op_sub, op_dec: begin
        result = issue.a - issue.b;
        is_sub = 1'b1;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // ref_val is always one of a and b, so the register sign is the other one
  assign same_sign = (issue.a[data_width-1] == issue.b[data_width-1]);
  assign sign_flip = (result[data_width-1] != issue.ref_val[data_width-1]);

  assign ovf = same_sign && sign_flip;

  // carry on wrap below ref, borrow on wrap above it
  assign carry = is_sub ? (result > issue.ref_val) : (result < issue.ref_val);

endmodule

// File: src/bitwise_unit.sv
module bitwise_unit
  import alu_pkg::*;
(
  operand_if.consumer issue,
  output data_t       result
);

  data_t ror_stage [0:shamt_width];
  data_t rol_stage [0:shamt_width];

  assign ror_stage[0] = issue.a;
  assign rol_stage[0] = issue.a;

  // barrel rotator, one stage per bit of b[3:0]
  for (genvar i = 0; i < shamt_width; i++) begin : g_rot
    localparam int step = 1 << i;

    assign ror_stage[i+1] = issue.b[i] ?
                            {ror_stage[i][step-1:0], ror_stage[i][data_width-1:step]} :
                            ror_stage[i];

    assign rol_stage[i+1] = issue.b[i] ?
                            {rol_stage[i][data_width-step-1:0],
                             rol_stage[i][data_width-1:data_width-step]} :
                            rol_stage[i];
  end

  always_comb begin
    case (issue.op)
      op_and: begin
        result = issue.a & issue.b;
      end
      op_or: begin
        result = issue.a | issue.b;
      end
      op_xor: begin
        result = issue.a ^ issue.b;
      end
      op_not: begin
        result = ~issue.a;
      end
      op_shr: begin
        result = issue.a >> issue.b;  // 16 or more clears
      end
      op_shl: begin
        result = issue.a << issue.b;
      end
      op_ror: begin
        result = ror_stage[shamt_width];
      end
      op_rol: begin
        result = rol_stage[shamt_width];
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: src/flag_result_reg.sv
module flag_result_reg
  import alu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  operand_if.consumer issue,
  input  data_t       arith_result,
  input  logic        arith_ovf,
  input  logic        arith_carry,
  input  data_t       logic_result,
  output data_t       res,
  output flags_t      flags,
  output logic        res_valid
);

  logic   arith_sel;
  data_t  res_next;
  flags_t flags_next;

  always_comb begin
    arith_sel                = is_arith(issue.op);
    res_next                 = arith_sel ? arith_result : logic_result;
    flags_next[flag_ovf]     = arith_sel & arith_ovf;  // zero for bitwise ops
    flags_next[flag_carry]   = arith_sel & arith_carry;
    flags_next[flag_neg]     = res_next[data_width-1];
    flags_next[flag_zero]    = (res_next == '0);
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      res       <= '0;
      flags     <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= issue.valid;
      if (issue.valid) begin  // hold until next result
        res   <= res_next;
        flags <= flags_next;
      end
    end
  end

endmodule

// File: src/alu_top.sv
module alu_top
  import alu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    en,
  input  alu_op_e opcode,
  input  data_t   acc,
  input  data_t   x,
  input  data_t   y,
  input  data_t   immediate,
  input  logic    ra,
  output data_t   res,
  output flags_t  flags,
  output logic    res_valid
);

  data_t arith_result;
  logic  arith_ovf;
  logic  arith_carry;
  data_t logic_result;

  operand_if issue ();

  operand_select u_operand_select (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .opcode    (opcode),
    .acc       (acc),
    .x         (x),
    .y         (y),
    .immediate (immediate),
    .ra        (ra),
    .issue     (issue.producer)
  );

  arith_unit u_arith_unit (
    .issue  (issue.consumer),
    .result (arith_result),
    .ovf    (arith_ovf),
    .carry  (arith_carry)
  );

  bitwise_unit u_bitwise_unit (
    .issue  (issue.consumer),
    .result (logic_result)
  );

  flag_result_reg u_flag_result_reg (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue.consumer),
    .arith_result (arith_result),
    .arith_ovf    (arith_ovf),
    .arith_carry  (arith_carry),
    .logic_result (logic_result),
    .res          (res),
    .flags        (flags),
    .res_valid    (res_valid)
  );

endmodule

// File: verification/alu_assert.sv
module alu_assert
  import alu_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    en,
  input alu_op_e opcode,
  input logic    res_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  logic strobe;

  assign strobe = en && (opcode inside {op_add, op_sub, op_shr, op_shl, op_mul, op_inc,
                                        op_dec, op_and, op_or, op_xor, op_not, op_ror,
                                        op_rol});

  // a result needs an accepted strobe two edges back, out of reset
  a_no_spurious_valid: assert property (
    @(posedge clk) disable iff (!rst)
    res_valid |-> $past(strobe && rst, 2) && $past(rst)
  ) else $error("res_valid high without a strobe two edges earlier");

  a_fixed_latency: assert property (
    @(posedge clk) disable iff (!rst)
    strobe |-> ##2 res_valid
  ) else $error("res_valid did not follow a strobe after two edges");

  a_single_pulse: assert property (
    @(posedge clk) disable iff (!rst)
    res_valid && $past(res_valid) |-> $past(strobe, 2) && $past(strobe, 3)
  ) else $error("res_valid held high without back to back strobes");

endmodule

bind alu_top alu_assert u_alu_assert (
  .clk       (clk),
  .rst       (rst),
  .en        (en),
  .opcode    (opcode),
  .res_valid (res_valid)
);

// File: verification/alu_tb.sv
module alu_tb
  import alu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 10;
  localparam int latency      = 2;
  localparam int directed_ops = 72;
  localparam int random_ops   = 200;
  localparam int num_tests    = 6;
  // every test ends with a drain of a few idle cycles
  localparam int test_cycles  = 2 * reset_cycles + directed_ops + random_ops +
                                num_tests * (latency + 4);
  localparam int max_cycles   = test_cycles * 3 / 2;

  logic    clk;
  logic    rst;
  logic    en;
  alu_op_e opcode;
  data_t   acc;
  data_t   x;
  data_t   y;
  data_t   immediate;
  logic    ra;
  data_t   res;
  flags_t  flags;
  logic    res_valid;

  data_t       exp_res_q[$];
  flags_t      exp_flags_q[$];
  int          exp_due_q[$];  // cycle at which each result must show up
  int          cycle = 0;
  logic [31:0] lcg_state = 32'h95fc091f;

  alu_op_e kept_ops [0:12] = '{op_add, op_sub, op_shr, op_shl, op_mul, op_inc, op_dec,
                               op_and, op_or, op_xor, op_not, op_ror, op_rol};

  alu_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .opcode    (opcode),
    .acc       (acc),
    .x         (x),
    .y         (y),
    .immediate (immediate),
    .ra        (ra),
    .res       (res),
    .flags     (flags),
    .res_valid (res_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    stop_run();
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      abort_run("timeout, the run went past its cycle limit");
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic op_is_kept(input alu_op_e op);
    foreach (kept_ops[i]) begin
      if (kept_ops[i] == op) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // expected {flags, res} straight from the operand and flag rules
  function automatic logic [19:0] model_alu(input alu_op_e op, input data_t acc_v,
                                            input data_t x_v, input data_t y_v,
                                            input data_t imm_v, input logic ra_v);
    data_t       reg_v;
    data_t       opa;
    data_t       opb;
    data_t       ref_v;
    data_t       out;
    logic [31:0] wide;
    flags_t      f;
    reg_v = ra_v ? y_v : x_v;
    if (op == op_inc || op == op_dec) begin
      opa   = reg_v;
      opb   = 16'h0001;
      ref_v = 16'h0001;
    end else if (op == op_not) begin
      opa   = reg_v;
      opb   = imm_v;
      ref_v = imm_v;
    end else if (imm_v == 16'h0000) begin  // accumulator path
      opa   = acc_v;
      opb   = reg_v;
      ref_v = acc_v;
    end else if (op == op_add || op == op_mul) begin
      opa   = imm_v;
      opb   = reg_v;
      ref_v = imm_v;
    end else begin
      opa   = reg_v;
      opb   = imm_v;
      ref_v = imm_v;
    end
    wide = 32'h0;
    case (op)
      op_add, op_inc: out = opa + opb;
      op_sub, op_dec: out = opa - opb;
      op_mul: begin
        wide = {16'h0, opa} * {16'h0, opb};
        out  = wide[15:0];
      end
      op_and: out = opa & opb;
      op_or:  out = opa | opb;
      op_xor: out = opa ^ opb;
      op_not: out = ~opa;
      op_shr: out = (opb > 16'd15) ? 16'h0000 : opa >> opb[3:0];
      op_shl: out = (opb > 16'd15) ? 16'h0000 : opa << opb[3:0];
      op_ror: begin
        wide = {opa, opa} >> opb[3:0];
        out  = wide[15:0];
      end
      op_rol: begin
        wide = {opa, opa} << opb[3:0];
        out  = wide[31:16];
      end
      default: out = 16'h0000;
    endcase
    f = 4'h0;
    if (op inside {op_add, op_sub, op_mul, op_inc, op_dec}) begin
      f[flag_ovf] = (ref_v[15] == reg_v[15]) && (out[15] != ref_v[15]);
    end
    if (op == op_add || op == op_mul || op == op_inc) begin
      f[flag_carry] = out < ref_v;
    end else if (op == op_sub || op == op_dec) begin
      f[flag_carry] = out > ref_v;  // borrow
    end
    f[flag_neg]  = out[15];
    f[flag_zero] = (out == 16'h0000);
    return {f, out};
  endfunction

  task automatic drive_op(input alu_op_e op, input data_t acc_v, input data_t x_v,
                          input data_t y_v, input data_t imm_v, input logic ra_v);
    @(posedge clk);
    en        <= 1'b1;
    opcode    <= op;
    acc       <= acc_v;
    x         <= x_v;
    y         <= y_v;
    immediate <= imm_v;
    ra        <= ra_v;
  endtask

  // called in the same time step as the driving edge
  task automatic push_expected(input data_t want_res, input flags_t want_flags);
    exp_res_q.push_back(want_res);
    exp_flags_q.push_back(want_flags);
    exp_due_q.push_back(cycle + latency + 1);
  endtask

  task automatic issue_op(input alu_op_e op, input data_t acc_v, input data_t x_v,
                          input data_t y_v, input data_t imm_v, input logic ra_v);
    logic [19:0] want;
    drive_op(op, acc_v, x_v, y_v, imm_v, ra_v);
    if (op_is_kept(op)) begin
      want = model_alu(op, acc_v, x_v, y_v, imm_v, ra_v);
      push_expected(want[15:0], want[19:16]);
    end
  endtask

  task automatic issue_exact(input alu_op_e op, input data_t acc_v, input data_t x_v,
                             input data_t y_v, input data_t imm_v, input logic ra_v,
                             input data_t want_res, input flags_t want_flags);
    drive_op(op, acc_v, x_v, y_v, imm_v, ra_v);
    push_expected(want_res, want_flags);
  endtask

  task automatic finish_burst();
    int waited;
    waited = 0;
    @(posedge clk);
    en <= 1'b0;
    while (exp_res_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > latency + 2) begin
        abort_run("an issued operation never produced a result");
      end
    end
  endtask

  task automatic check_idle_outputs();
    @(negedge clk);
    check_eq(32'(res), 32'h0, "res after reset");
    check_eq(32'(flags), 32'h0, "flags after reset");
    check_eq(32'(res_valid), 32'h0, "res_valid after reset");
  endtask

  always @(negedge clk) begin
    if (rst && res_valid) begin
      if (exp_res_q.size() == 0) begin
        abort_run("res_valid rose with no operation waiting for a result");
      end else begin
        check_eq(32'(cycle), 32'(exp_due_q.pop_front()), "result arrival cycle");
        check_eq(32'(res), 32'(exp_res_q.pop_front()), "res");
        check_eq(32'(flags), 32'(exp_flags_q.pop_front()), "flags");
      end
    end
  end

  task automatic test_add_sub();
    issue_exact(op_add, 16'h7fff, 16'h0001, 16'h0000, 16'h0000, 1'b0, 16'h8000, 4'b0101);
    issue_exact(op_add, 16'hffff, 16'h0000, 16'h0001, 16'h0000, 1'b1, 16'h0000, 4'b1010);
    issue_op(op_add, 16'h0000, 16'h1111, 16'h2222, 16'h1234, 1'b0);
    issue_op(op_add, 16'h0000, 16'h1111, 16'h9000, 16'h9000, 1'b1);  // both negative
    issue_exact(op_sub, 16'h0005, 16'h0005, 16'h0000, 16'h0000, 1'b0, 16'h0000, 4'b1000);
    issue_exact(op_sub, 16'h0003, 16'h0000, 16'h0005, 16'h0000, 1'b1, 16'hfffe, 4'b0111);
    issue_op(op_sub, 16'h0000, 16'h8000, 16'h0000, 16'h0001, 1'b0);
    issue_op(op_sub, 16'hbeef, 16'h0000, 16'h0040, 16'h0004, 1'b1);
    issue_exact(op_sub, 16'h0000, 16'h0001, 16'h0000, 16'h0002, 1'b0, 16'hffff, 4'b0111);
    finish_burst();
  endtask

  task automatic test_mul_inc_dec();
    issue_exact(op_inc, 16'h0000, 16'hffff, 16'h0000, 16'h0000, 1'b0, 16'h0000, 4'b1010);
    issue_exact(op_dec, 16'h0000, 16'h1234, 16'h0000, 16'h0000, 1'b1, 16'hffff, 4'b0111);
    issue_exact(op_inc, 16'h5555, 16'h7fff, 16'h0000, 16'h0033, 1'b0, 16'h8000, 4'b0101);
    issue_op(op_dec, 16'h0000, 16'h0000, 16'h0005, 16'h0000, 1'b1);
    issue_exact(op_mul, 16'h0100, 16'h0100, 16'h0000, 16'h0000, 1'b0, 16'h0000, 4'b1010);
    issue_op(op_mul, 16'h0000, 16'h0000, 16'h0005, 16'h0003, 1'b1);
    issue_op(op_mul, 16'hfffe, 16'h0003, 16'h0000, 16'h0000, 1'b0);
    finish_burst();
  endtask

  task automatic test_logic_ops();
    alu_op_e logic_ops [4] = '{op_and, op_or, op_xor, op_not};
    foreach (logic_ops[i]) begin
      issue_op(logic_ops[i], 16'hf0f0, 16'hff00, 16'h0ff0, 16'h0000, (i % 2) == 1);
      issue_op(logic_ops[i], 16'hf0f0, 16'hff00, 16'h0ff0, 16'h3c3c, (i % 2) == 0);
    end
    issue_exact(op_xor, 16'ha5a5, 16'h0000, 16'ha5a5, 16'h0000, 1'b1, 16'h0000, 4'b1000);
    issue_exact(op_and, 16'hffff, 16'h8000, 16'h0000, 16'h0000, 1'b0, 16'h8000, 4'b0100);
    issue_exact(op_not, 16'h1234, 16'h0000, 16'h0000, 16'h0001, 1'b0, 16'hffff, 4'b0100);
    finish_burst();
  endtask

  task automatic test_shift_rotate();
    int      counts [5] = '{0, 1, 15, 16, 17};
    alu_op_e shift_ops [4] = '{op_shr, op_shl, op_ror, op_rol};
    foreach (shift_ops[i]) begin
      foreach (counts[j]) begin
        issue_op(shift_ops[i], 16'h8421, data_t'(counts[j]), 16'h0000, 16'h0000, 1'b0);
        if (counts[j] != 0) begin  // count 0 only exists on the acc path
          issue_op(shift_ops[i], 16'h0000, 16'h0000, 16'hc003, data_t'(counts[j]), 1'b1);
        end
      end
    end
    issue_exact(op_shr, 16'h8421, 16'd16, 16'h0000, 16'h0000, 1'b0, 16'h0000, 4'b1000);
    issue_exact(op_rol, 16'h8001, 16'd17, 16'h0000, 16'h0000, 1'b0, 16'h0003, 4'b0000);
    issue_exact(op_ror, 16'h8001, 16'd16, 16'h0000, 16'h0000, 1'b0, 16'h8001, 4'b0100);
    issue_exact(op_shl, 16'h0000, 16'h0001, 16'h0000, 16'd15, 1'b0, 16'h8000, 4'b0100);
    finish_burst();
  endtask

  task automatic test_random_burst();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    alu_op_e     op;
    data_t       imm_v;
    repeat (random_ops) begin
      r1    = next_random();
      r2    = next_random();
      r3    = next_random();
      op    = kept_ops[r1 % 32'd13];
      imm_v = (r1[9:8] == 2'b00) ? 16'h0000 : r3[15:0];  // acc path one time in four
      if (imm_v != 16'h0000 && r1[20]) begin
        imm_v = {11'h000, r3[4:0]};  // small counts for shifts and rotates
      end
      issue_op(op, r2[31:16], r2[15:0], r3[31:16], imm_v, r1[12]);
    end
    finish_burst();
  endtask

  task automatic test_reset_unknown();
    issue_op(op_add, 16'h1234, 16'h0101, 16'h0000, 16'h0000, 1'b0);
    finish_burst();
    @(posedge clk);
    rst <= 1'b0;
    repeat (reset_cycles - 1) @(posedge clk);
    check_idle_outputs();
    @(posedge clk);
    rst <= 1'b1;
    issue_op(alu_op_e'(6'b010010), 16'h0009, 16'h0003, 16'h0000, 16'h0000, 1'b0);  // divide
    issue_op(alu_op_e'(6'b011101), 16'h0004, 16'h0001, 16'h0000, 16'h0000, 1'b0);  // factorial
    issue_op(alu_op_e'(6'b010100), 16'h0007, 16'h0002, 16'h0000, 16'h0000, 1'b0);
    @(posedge clk);
    en <= 1'b0;
    repeat (latency + 2) begin
      @(negedge clk);
      check_eq(32'(res_valid), 32'h0, "res_valid after a dropped opcode");
    end
    issue_op(op_sub, 16'h0000, 16'h0010, 16'h0000, 16'h0001, 1'b0);
    finish_burst();
  endtask

  initial begin
    rst       = 1'b0;
    en        = 1'b0;
    opcode    = op_add;
    acc       = 16'h0000;
    x         = 16'h0000;
    y         = 16'h0000;
    immediate = 16'h0000;
    ra        = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b1;
    check_idle_outputs();
    test_add_sub();
    test_mul_inc_dec();
    test_logic_ops();
    test_shift_rotate();
    test_random_burst();
    test_reset_unknown();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: tb.f
src/alu_pkg.sv
src/operand_if.sv
src/operand_select.sv
src/arith_unit.sv
src/bitwise_unit.sv
src/flag_result_reg.sv
src/alu_top.sv
verification/alu_assert.sv
verification/alu_tb.sv

// File: Makefile
SRCS = $(filter-out +%,$(shell cat tb.f))

obj_dir/Valu_tb: tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module alu_tb -f tb.f

run: obj_dir/Valu_tb
	obj_dir/Valu_tb > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
